// ==== all.f ====
+incdir+hw
+incdir+sim
hw/rv_inst_pkg.sv
hw/trace_pkg.sv
hw/csr_snapshot_ram.sv
hw/store_tracker.sv
hw/commit_decode.sv
hw/trace_assemble.sv
hw/trace_counters.sv
hw/commit_trace.sv
sim/tb_commit_trace.sv

// ==== hw/commit_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module commit_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmt_valid,
    input  trace_pkg::commit_t  cmt,
    output logic                cmt_ready,
    output logic                dec_valid,
    output trace_pkg::decoded_t dec,
    input  logic                dec_ready
);
    import trace_pkg::*;
    import rv_inst_pkg::*;

    logic        sys_csr;    // csrrw and friends
    logic        gpr_class;  // opcode writes rd
    logic [11:0] csr_addr;
    decoded_t    dec_d;

    always_comb begin
        sys_csr = (cmt.inst.itype.opcode == OP_SYSTEM) && (cmt.inst.itype.funct3 != 3'd0);
        case (cmt.inst.rtype.opcode)
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD,
            OP_IMM, OP_REG, OP_IMM32, OP_REG32: gpr_class = 1'b1;
            OP_SYSTEM:                          gpr_class = sys_csr;
            OP_STORE, OP_BRANCH:                gpr_class = 1'b0;
            default:                            gpr_class = 1'b0;
        endcase
    end

    // supervisor and user views folded onto machine addresses
    always_comb begin
        csr_addr = cmt.inst.itype.imm;
        if (csr_addr == CSR_SSTATUS || csr_addr == CSR_SIE || csr_addr == CSR_SIP) begin
            csr_addr = csr_addr + 12'h200;
        end else if (csr_addr >= CSR_CYCLE && csr_addr <= CSR_INSTRET) begin
            csr_addr = csr_addr - 12'h100;  // cycle, time, instret
        end
    end

    always_comb begin
        dec_d.tag       = cmt.tag;
        dec_d.pc        = cmt.pc;
        dec_d.inst      = cmt.inst;
        dec_d.result    = cmt.result;
        dec_d.st_id     = cmt.st_id;
        dec_d.csr_wdata = cmt.csr_wdata;
        dec_d.gpr_we    = gpr_class && (cmt.inst.rtype.rd != 5'd0);
        dec_d.gpr_addr  = cmt.inst.rtype.rd;
        dec_d.csr_we    = sys_csr;
        dec_d.csr_addr  = csr_addr;
        dec_d.is_store  = (cmt.inst.rtype.opcode == OP_STORE);
    end

    assign cmt_ready = !dec_valid || dec_ready;  // empty or draining

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (cmt_ready) begin
            dec_valid <= cmt_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmt_valid && cmt_ready) begin
            dec <= dec_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/commit_trace.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "trace_cfg.svh"

module commit_trace (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     disp_valid,
    input  logic [`TRACE_TAG_W-1:0]  disp_tag,
    input  trace_pkg::csr_snap_t     disp_snap,
    input  logic                     st_valid,
    input  logic [`TRACE_STID_W-1:0] st_id,
    input  logic [`TRACE_XLEN-1:0]   st_addr,
    input  logic [`TRACE_XLEN-1:0]   st_wdata,
    input  logic [`TRACE_STRB_W-1:0] st_strb,
    input  logic                     cmt_valid,
    input  trace_pkg::commit_t       cmt,
    output logic                     cmt_ready,
    output logic                     trace_valid,
    output trace_pkg::trace_rec_t    trace,
    input  logic                     trace_ready,
    output trace_pkg::trace_cnt_t    counts
);
    import trace_pkg::*;

    logic                     dec_valid;
    logic                     dec_ready;
    decoded_t                 dec;
    logic                     snap_rd_en;
    logic [`TRACE_TAG_W-1:0]  snap_tag;
    csr_snap_t                snap;
    logic                     st_rd_en;
    logic [`TRACE_STID_W-1:0] st_rd_id;
    store_rec_t               st_rec;

    csr_snapshot_ram u_snap (
        .clk     (clk),
        .wr_en   (disp_valid),
        .wr_tag  (disp_tag),
        .wr_snap (disp_snap),
        .rd_en   (snap_rd_en),
        .rd_tag  (snap_tag),
        .rd_snap (snap)
    );

    store_tracker u_store (
        .clk      (clk),
        .st_valid (st_valid),
        .st_id    (st_id),
        .st_addr  (st_addr),
        .st_wdata (st_wdata),
        .st_strb  (st_strb),
        .rd_en    (st_rd_en),
        .rd_id    (st_rd_id),
        .rd_rec   (st_rec)
    );

    commit_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .cmt_valid (cmt_valid),
        .cmt       (cmt),
        .cmt_ready (cmt_ready),
        .dec_valid (dec_valid),
        .dec       (dec),
        .dec_ready (dec_ready)
    );

    trace_assemble u_assemble (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec         (dec),
        .dec_ready   (dec_ready),
        .snap_rd_en  (snap_rd_en),
        .snap_tag    (snap_tag),
        .snap        (snap),
        .st_rd_en    (st_rd_en),
        .st_rd_id    (st_rd_id),
        .st_rec      (st_rec),
        .trace_valid (trace_valid),
        .trace       (trace),
        .trace_ready (trace_ready)
    );

    trace_counters u_counters (
        .clk    (clk),
        .rst    (rst),
        .fire   (trace_valid && trace_ready),  // sink took the record
        .rec    (trace),
        .counts (counts)
    );

endmodule

`default_nettype wire

// ==== hw/csr_snapshot_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "trace_cfg.svh"

module csr_snapshot_ram (
    input  logic                    clk,
    input  logic                    wr_en,
    input  logic [`TRACE_TAG_W-1:0] wr_tag,
    input  trace_pkg::csr_snap_t    wr_snap,
    input  logic                    rd_en,
    input  logic [`TRACE_TAG_W-1:0] rd_tag,
    output trace_pkg::csr_snap_t    rd_snap
);
    import trace_pkg::*;

    csr_snap_t mem [1 << `TRACE_TAG_W];  // one entry per rob tag

    // dispatch side
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_tag] <= wr_snap;
        end
    end

    // commit side, output holds while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_snap <= mem[rd_tag];
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_inst_pkg.sv ====
`default_nettype none

package rv_inst_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rtype_t;

    typedef struct packed {
        logic [11:0] imm;  // csr address for SYSTEM
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } itype_t;

    // one instruction word, two field layouts
    typedef union packed {
        rtype_t rtype;
        itype_t itype;
    } rv_inst_u;

    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM32  = 7'b0011011;
    localparam logic [6:0] OP_REG32  = 7'b0111011;

    localparam logic [11:0] CSR_SSTATUS = 12'h100;
    localparam logic [11:0] CSR_SIE     = 12'h104;
    localparam logic [11:0] CSR_SIP     = 12'h144;
    localparam logic [11:0] CSR_CYCLE   = 12'hc00;
    localparam logic [11:0] CSR_INSTRET = 12'hc02;

endpackage

`default_nettype wire

// ==== hw/store_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "trace_cfg.svh"

module store_tracker (
    input  logic                     clk,
    input  logic                     st_valid,
    input  logic [`TRACE_STID_W-1:0] st_id,
    input  logic [`TRACE_XLEN-1:0]   st_addr,
    input  logic [`TRACE_XLEN-1:0]   st_wdata,
    input  logic [`TRACE_STRB_W-1:0] st_strb,
    input  logic                     rd_en,
    input  logic [`TRACE_STID_W-1:0] rd_id,
    output trace_pkg::store_rec_t    rd_rec
);
    import trace_pkg::*;

    logic [$clog2(`TRACE_STRB_W)-1:0] lane;  // lowest enabled lane
    logic [$clog2(`TRACE_STRB_W):0]   cnt;
    store_rec_t                       wr_rec;
    store_rec_t                       table_q [1 << `TRACE_STID_W];

    // scan from the top so the lowest set lane wins
    always_comb begin
        lane = '0;
        cnt  = '0;
        for (int i = `TRACE_STRB_W - 1; i >= 0; i--) begin
            if (st_strb[i]) begin
                lane = ($clog2(`TRACE_STRB_W))'(i);
                cnt  = cnt + 1'b1;
            end
        end
    end

    always_comb begin
        wr_rec.addr = st_addr;
        wr_rec.data = st_wdata >> {lane, 3'b000};  // bytes to bits
        wr_rec.size = cnt;
    end

    always_ff @(posedge clk) begin
        if (st_valid) begin
            table_q[st_id] <= wr_rec;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_rec <= table_q[rd_id];
        end
    end

endmodule

`default_nettype wire

// ==== hw/trace_assemble.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "trace_cfg.svh"

module trace_assemble (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dec_valid,
    input  trace_pkg::decoded_t      dec,
    output logic                     dec_ready,
    output logic                     snap_rd_en,
    output logic [`TRACE_TAG_W-1:0]  snap_tag,
    input  trace_pkg::csr_snap_t     snap,
    output logic                     st_rd_en,
    output logic [`TRACE_STID_W-1:0] st_rd_id,
    input  trace_pkg::store_rec_t    st_rec,
    output logic                     trace_valid,
    output trace_pkg::trace_rec_t    trace,
    input  logic                     trace_ready
);
    import trace_pkg::*;

    logic     accept;
    decoded_t dq;  // decoded fields held alongside the table reads

    assign dec_ready = !trace_valid || trace_ready;
    assign accept    = dec_valid && dec_ready;

    // table reads land in the same edge as dq
    assign snap_rd_en = accept;
    assign snap_tag   = dec.tag;
    assign st_rd_en   = accept && dec.is_store;
    assign st_rd_id   = dec.st_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            trace_valid <= 1'b0;
        end else if (dec_ready) begin
            trace_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dq <= dec;
        end
    end

    always_comb begin
        trace.pc        = dq.pc;
        trace.inst      = dq.inst;
        trace.gpr_we    = dq.gpr_we;
        trace.gpr_addr  = dq.gpr_addr;
        trace.gpr_value = dq.result;
        trace.csr_we    = dq.csr_we;
        trace.csr_addr  = dq.csr_addr;
        trace.csr_value = dq.csr_we ? dq.csr_wdata : '0;
        trace.mem_size  = dq.is_store ? st_rec.size : '0;  // zero for non-stores
        trace.mem_addr  = dq.is_store ? st_rec.addr : '0;
        trace.mem_data  = dq.is_store ? st_rec.data : '0;
        trace.snap      = snap;
    end

endmodule

`default_nettype wire

// ==== hw/trace_cfg.svh ====
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// data path width of the core
`define TRACE_XLEN 64

// reorder buffer tag, one snapshot entry per tag
`define TRACE_TAG_W 7

// store id, one store table entry per id
`define TRACE_STID_W 4

// byte lanes of a store word
`define TRACE_STRB_W 8

// width of each event counter
`define TRACE_CNT_W 32

`endif

// ==== hw/trace_counters.sv ====
`timescale 1ns/100ps
`default_nettype none

module trace_counters (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fire,
    input  trace_pkg::trace_rec_t rec,
    output trace_pkg::trace_cnt_t counts
);

    // one step per accepted trace record
    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else if (fire) begin
            counts.records <= counts.records + 1'b1;
            if (rec.gpr_we) begin
                counts.gpr_writes <= counts.gpr_writes + 1'b1;
            end
            if (rec.csr_we) begin
                counts.csr_writes <= counts.csr_writes + 1'b1;
            end
            if (rec.mem_size != '0) begin
                counts.stores <= counts.stores + 1'b1;  // stores with live lanes
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/trace_pkg.sv ====
`default_nettype none

`include "trace_cfg.svh"

package trace_pkg;

    // machine csr state seen by an instruction at dispatch
    typedef struct packed {
        logic [`TRACE_XLEN-1:0] mstatus;
        logic [`TRACE_XLEN-1:0] mtvec;
        logic [`TRACE_XLEN-1:0] mcause;
        logic [`TRACE_XLEN-1:0] mepc;
    } csr_snap_t;

    typedef struct packed {
        logic [`TRACE_XLEN-1:0]         addr;
        logic [`TRACE_XLEN-1:0]         data;  // shifted down to lowest lane
        logic [$clog2(`TRACE_STRB_W):0] size;  // enabled lane count
    } store_rec_t;

    // retired instruction from the core
    typedef struct packed {
        logic [`TRACE_TAG_W-1:0]  tag;
        logic [`TRACE_XLEN-1:0]   pc;
        rv_inst_pkg::rv_inst_u    inst;
        logic [`TRACE_XLEN-1:0]   result;
        logic [`TRACE_STID_W-1:0] st_id;
        logic [`TRACE_XLEN-1:0]   csr_wdata;
    } commit_t;

    typedef struct packed {
        logic [`TRACE_TAG_W-1:0]  tag;
        logic [`TRACE_XLEN-1:0]   pc;
        rv_inst_pkg::rv_inst_u    inst;
        logic [`TRACE_XLEN-1:0]   result;
        logic [`TRACE_STID_W-1:0] st_id;
        logic [`TRACE_XLEN-1:0]   csr_wdata;
        logic                     gpr_we;
        logic [4:0]               gpr_addr;
        logic                     csr_we;
        logic [11:0]              csr_addr;   // already aliased
        logic                     is_store;
    } decoded_t;

    // one record per committed instruction
    typedef struct packed {
        logic [`TRACE_XLEN-1:0]         pc;
        rv_inst_pkg::rv_inst_u          inst;
        logic                           gpr_we;
        logic [4:0]                     gpr_addr;
        logic [`TRACE_XLEN-1:0]         gpr_value;
        logic                           csr_we;
        logic [11:0]                    csr_addr;
        logic [`TRACE_XLEN-1:0]         csr_value;
        logic [$clog2(`TRACE_STRB_W):0] mem_size;
        logic [`TRACE_XLEN-1:0]         mem_addr;
        logic [`TRACE_XLEN-1:0]         mem_data;
        csr_snap_t                      snap;
    } trace_rec_t;

    typedef struct packed {
        logic [`TRACE_CNT_W-1:0] records;
        logic [`TRACE_CNT_W-1:0] gpr_writes;
        logic [`TRACE_CNT_W-1:0] csr_writes;
        logic [`TRACE_CNT_W-1:0] stores;
    } trace_cnt_t;

endpackage

`default_nettype wire

// ==== sim/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 32-bit lcg, numerical recipes constants
function automatic logic [31:0] lcg(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
endfunction

// supervisor and user views of machine csrs
function automatic logic [11:0] alias_csr(input logic [11:0] addr);
    case (addr)
        12'h100, 12'h104, 12'h144: return addr + 12'h200;
        12'hc00, 12'hc01, 12'hc02: return addr - 12'h100;
        default:                   return addr;
    endcase
endfunction

function automatic logic writes_gpr(input logic [31:0] w);
    if (w[11:7] == 5'd0) begin
        return 1'b0;  // x0 is never written
    end
    case (w[6:0])
        7'h37, 7'h17, 7'h6f, 7'h67, 7'h03, 7'h13, 7'h33, 7'h1b, 7'h3b: return 1'b1;
        7'h73:   return w[14:12] != 3'd0;
        default: return 1'b0;
    endcase
endfunction

function automatic store_rec_t store_model(input logic [`TRACE_XLEN-1:0] addr,
                                           input logic [`TRACE_XLEN-1:0] wdata,
                                           input logic [`TRACE_STRB_W-1:0] strb);
    store_rec_t r;
    int         low;
    low    = 0;
    r.size = '0;
    while (low < `TRACE_STRB_W && !strb[low]) begin
        low++;
    end
    if (low == `TRACE_STRB_W) begin
        low = 0;  // empty strobe, no shift
    end
    for (int i = 0; i < `TRACE_STRB_W; i++) begin
        if (strb[i]) begin
            r.size = r.size + 1'b1;
        end
    end
    r.addr = addr;
    r.data = wdata >> (8 * low);
    return r;
endfunction

function automatic trace_rec_t expect_rec(input commit_t c, input csr_snap_t s,
                                          input store_rec_t st);
    trace_rec_t  r;
    logic [31:0] w;
    logic        csr_op;
    logic        st_op;
    w           = c.inst;
    csr_op      = (w[6:0] == 7'h73) && (w[14:12] != 3'd0);
    st_op       = (w[6:0] == 7'h23);
    r.pc        = c.pc;
    r.inst      = c.inst;
    r.gpr_we    = writes_gpr(w);
    r.gpr_addr  = w[11:7];
    r.gpr_value = c.result;
    r.csr_we    = csr_op;
    r.csr_addr  = alias_csr(w[31:20]);
    r.csr_value = csr_op ? c.csr_wdata : '0;
    r.mem_size  = st_op ? st.size : '0;
    r.mem_addr  = st_op ? st.addr : '0;
    r.mem_data  = st_op ? st.data : '0;
    r.snap      = s;
    return r;
endfunction

`endif

// ==== sim/tb_commit_trace.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "trace_cfg.svh"

module tb_commit_trace;
    import trace_pkg::*;
    import rv_inst_pkg::*;

    `include "tb_model.svh"

    localparam int STIM_CYCLES = 16 + 99 * 3;  // snapshot writes, then 3 edges per commit
    localparam int CYCLE_LIMIT = 4 * STIM_CYCLES + 100;

    logic                     clk;
    logic                     rst;
    logic                     disp_valid;
    logic [`TRACE_TAG_W-1:0]  disp_tag;
    csr_snap_t                disp_snap;
    logic                     st_valid;
    logic [`TRACE_STID_W-1:0] st_id;
    logic [`TRACE_XLEN-1:0]   st_addr;
    logic [`TRACE_XLEN-1:0]   st_wdata;
    logic [`TRACE_STRB_W-1:0] st_strb;
    logic                     cmt_valid;
    commit_t                  cmt;
    logic                     cmt_ready;
    logic                     trace_valid;
    trace_rec_t               trace;
    logic                     trace_ready;
    trace_cnt_t               counts;

    logic [31:0]              seed;
    logic [31:0]              rdy_seed;
    logic [31:0]              rdy_bits;
    csr_snap_t                snap_m [1 << `TRACE_TAG_W];
    store_rec_t               st_m [1 << `TRACE_STID_W];
    trace_rec_t               exp_q [$];
    int                       edge_q [$];  // commit transfer edges
    trace_cnt_t               tally;
    string                    test_name;
    int                       cycles;
    int                       errors;
    int                       test_errs;
    int                       checks;
    int                       test_checks;
    int                       tests;
    logic                     bp_mode;
    logic                     lat_check;
    logic [`TRACE_TAG_W-1:0]  next_tag;
    logic [`TRACE_STID_W-1:0] next_sid;
    logic [`TRACE_TAG_W-1:0]  tags [16];
    logic [11:0]              csr_list [7];
    logic [6:0]               op_list [12];

    commit_trace u_dut (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_tag    (disp_tag),
        .disp_snap   (disp_snap),
        .st_valid    (st_valid),
        .st_id       (st_id),
        .st_addr     (st_addr),
        .st_wdata    (st_wdata),
        .st_strb     (st_strb),
        .cmt_valid   (cmt_valid),
        .cmt         (cmt),
        .cmt_ready   (cmt_ready),
        .trace_valid (trace_valid),
        .trace       (trace),
        .trace_ready (trace_ready),
        .counts      (counts)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // sink back-pressure
    always @(posedge clk) begin
        if (bp_mode) begin
            rdy_bits = lcg(rdy_seed);
            trace_ready <= rdy_bits[21];
        end else begin
            trace_ready <= 1'b1;
        end
    end

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg(seed);
        lo = lcg(seed);
        return {hi, lo};
    endfunction

    function automatic csr_snap_t rand_snap();
        csr_snap_t s;
        s.mstatus = rand64();
        s.mtvec   = rand64();
        s.mcause  = rand64();
        s.mepc    = rand64();
        return s;
    endfunction

    function automatic logic [31:0] make_inst(input logic [6:0] op);
        logic [31:0] w;
        w      = lcg(seed);
        w[6:0] = op;
        return w;
    endfunction

    task automatic check_field(input string what, input logic [255:0] exp,
                               input logic [255:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_record();
        trace_rec_t e;
        int         cmt_edge;
        assert (exp_q.size() > 0) else begin
            $display("%s: trace record came out with no commit pending", test_name);
            errors++;
            test_errs++;
        end
        if (exp_q.size() > 0) begin
            e        = exp_q.pop_front();
            cmt_edge = edge_q.pop_front();
            checks++;
            test_checks++;
            check_field("pc/inst", {e.pc, e.inst}, {trace.pc, trace.inst});
            check_field("gpr", {e.gpr_we, e.gpr_addr, e.gpr_value},
                        {trace.gpr_we, trace.gpr_addr, trace.gpr_value});
            check_field("csr", {e.csr_we, e.csr_addr, e.csr_value},
                        {trace.csr_we, trace.csr_addr, trace.csr_value});
            check_field("mem", {e.mem_size, e.mem_addr, e.mem_data},
                        {trace.mem_size, trace.mem_addr, trace.mem_data});
            check_field("snapshot", e.snap, trace.snap);
            if (lat_check) begin
                check_field("latency", 256'(2), 256'(cycles + 1 - cmt_edge));
            end
        end
    endtask

    // inputs only move on posedge, so negedge sees the values of the next edge
    always @(negedge clk) begin
        if (!rst && cmt_valid && cmt_ready) begin
            edge_q.push_back(cycles + 1);
        end
        if (!rst && trace_valid && trace_ready) begin
            check_record();
        end
    end

    task automatic write_snap(input logic [`TRACE_TAG_W-1:0] tag);
        csr_snap_t s;
        s = rand_snap();
        @(posedge clk);
        disp_valid <= 1'b1;
        disp_tag   <= tag;
        disp_snap  <= s;
        snap_m[tag] = s;
    endtask

    // one dispatch/store edge, then the commit held until accepted
    task automatic issue(input logic [31:0] word, input logic [`TRACE_TAG_W-1:0] tag,
                         input logic have_snap, input logic [`TRACE_STRB_W-1:0] strb);
        commit_t                c;
        trace_rec_t             e;
        csr_snap_t              s;
        logic [`TRACE_XLEN-1:0] addr;
        logic [`TRACE_XLEN-1:0] wdata;
        logic                   is_st;
        is_st       = (word[6:0] == 7'h23);
        s           = rand_snap();
        addr        = rand64();
        wdata       = rand64();
        c.tag       = tag;
        c.pc        = rand64();
        c.inst      = word;
        c.result    = rand64();
        c.st_id     = next_sid;
        c.csr_wdata = rand64();
        next_sid    = next_sid + 1'b1;
        @(posedge clk);
        disp_valid <= !have_snap;
        disp_tag   <= tag;
        disp_snap  <= s;
        st_valid   <= is_st;
        st_id      <= c.st_id;
        st_addr    <= addr;
        st_wdata   <= wdata;
        st_strb    <= strb;
        if (!have_snap) begin
            snap_m[tag] = s;
        end
        if (is_st) begin
            st_m[c.st_id] = store_model(addr, wdata, strb);
        end
        @(posedge clk);
        disp_valid <= 1'b0;
        st_valid   <= 1'b0;
        cmt_valid  <= 1'b1;
        cmt        <= c;
        e = expect_rec(c, snap_m[tag], st_m[c.st_id]);
        exp_q.push_back(e);
        tally.records = tally.records + 1'b1;
        tally.gpr_writes = tally.gpr_writes + e.gpr_we;
        tally.csr_writes = tally.csr_writes + e.csr_we;
        tally.stores = tally.stores + (e.mem_size != '0);
        @(negedge clk);
        while (!cmt_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        cmt_valid <= 1'b0;
    endtask

    task automatic issue_next(input logic [31:0] word, input logic [`TRACE_STRB_W-1:0] strb);
        issue(word, next_tag, 1'b0, strb);
        next_tag = next_tag + 1'b1;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);  // last transfer reaches the counters
        @(negedge clk);
    endtask

    task automatic finish_test();
        drain();
        $display("%-18s %0d records, %0d errors", test_name, test_checks, test_errs);
        tests++;
        test_checks = 0;
        test_errs   = 0;
    endtask

    initial begin
        logic [`TRACE_TAG_W-1:0] base;
        logic [`TRACE_TAG_W-1:0] step;
        logic [`TRACE_TAG_W-1:0] tmp;
        logic [31:0]             w;
        int                      j;
        seed        = 32'hccd6_12a9;
        rdy_seed    = ~seed;
        rst         = 1'b1;
        disp_valid  = 1'b0;
        disp_tag    = '0;
        disp_snap   = '0;
        st_valid    = 1'b0;
        st_id       = '0;
        st_addr     = '0;
        st_wdata    = '0;
        st_strb     = '0;
        cmt_valid   = 1'b0;
        cmt         = '0;
        trace_ready = 1'b1;
        bp_mode     = 1'b0;
        lat_check   = 1'b0;
        next_tag    = '0;
        next_sid    = '0;
        tally       = '0;
        csr_list = '{12'h100, 12'h104, 12'h144, 12'hc00, 12'hc01, 12'hc02, 12'h305};
        op_list  = '{7'h03, 7'h23, 7'h63, 7'h73, 7'h37, 7'h17,
                     7'h6f, 7'h67, 7'h13, 7'h33, 7'h1b, 7'h3b};
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_name = "snapshot_per_tag";
        base = lcg(seed);
        step = lcg(seed) | 1;  // odd step keeps the 16 tags distinct
        for (int i = 0; i < 16; i++) begin
            tags[i] = base + i * step;
            write_snap(tags[i]);
        end
        for (int i = 15; i > 0; i--) begin
            j       = int'(lcg(seed) % (i + 1));
            tmp     = tags[i];
            tags[i] = tags[j];
            tags[j] = tmp;
        end
        for (int i = 0; i < 16; i++) begin
            issue(make_inst(7'h13), tags[i], 1'b1, 8'hff);
        end
        finish_test();

        test_name = "csr_alias";
        for (int i = 0; i < 7; i++) begin
            w          = make_inst(7'h73);
            w[14:12]   = 3'b001;  // csrrw
            w[31:20]   = csr_list[i];
            issue_next(w, 8'h00);
        end
        finish_test();

        test_name = "store_tracking";
        for (int i = 0; i < 12; i++) begin
            w = lcg(seed);
            issue_next(make_inst(i[0] ? 7'h03 : 7'h23), (i == 0) ? 8'h00 : w[15:8]);
        end
        finish_test();

        test_name = "gpr_class";
        for (int i = 0; i < 12; i++) begin
            w        = make_inst(op_list[i]);
            w[11:7]  = 5'd0;
            issue_next(w, 8'h0f);
            w[11:7]  = 5'd1 + (lcg(seed) % 31);
            issue_next(w, 8'hf0);
        end
        finish_test();

        test_name = "back_pressure";
        bp_mode = 1'b1;
        for (int i = 0; i < 20; i++) begin
            w = lcg(seed);
            issue_next(make_inst(op_list[w[27:24] % 12]), w[7:0]);
        end
        drain();
        bp_mode   = 1'b0;
        lat_check = 1'b1;
        for (int i = 0; i < 20; i++) begin
            w = lcg(seed);
            issue_next(make_inst(op_list[w[27:24] % 12]), w[7:0]);
        end
        finish_test();
        lat_check = 1'b0;

        test_name = "counters";
        check_field("records", tally.records, counts.records);
        check_field("gpr_writes", tally.gpr_writes, counts.gpr_writes);
        check_field("csr_writes", tally.csr_writes, counts.csr_writes);
        check_field("stores", tally.stores, counts.stores);
        finish_test();

        $display("tests %0d, records checked %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
